// ==== source/mem_pkg.sv ====
// Shared constants and types of the memory stage
// Byte addresses index a word-organized data memory, no halfword size

package mem_pkg;

    // Load/store queue
    localparam int lsq_depth     = 8;
    localparam int lsq_ptr_width = 3;   // log2 of lsq_depth

    // ROB and datapath
    localparam int rob_tag_width = 4;
    localparam int data_width    = 32;

    // Data memory geometry
    localparam int mem_words      = 256;
    localparam int mem_addr_width = 10;  // Byte address, 4 bytes per word

    // Access size encoding
    localparam logic size_byte = 1'b0;
    localparam logic size_word = 1'b1;

    // One memory word, seen whole or as byte lanes
    typedef union packed {
        logic [data_width-1:0] word;
        logic [3:0][7:0]       lanes;  // Lane 0 is the least significant byte
    } mem_word_u;

endpackage

// ==== source/load_store_queue.sv ====
// In-order circular queue of loads and stores without disambiguation
// Accepts one enqueue and one dequeue in the same cycle

`timescale 1ns/1ns

module load_store_queue
    import mem_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      enq_valid,
    input  logic                      enq_is_store,
    input  logic                      enq_size,
    input  logic [mem_addr_width-1:0] enq_address,
    input  logic [data_width-1:0]     enq_data,
    input  logic [rob_tag_width-1:0]  enq_rob_tag,
    output logic                      enq_ready,
    input  logic                      deq,
    output logic                      head_valid,
    output logic                      head_is_store,
    output logic                      head_size,
    output logic [mem_addr_width-1:0] head_address,
    output logic [data_width-1:0]     head_data,
    output logic [rob_tag_width-1:0]  head_rob_tag
);

    // Entry payload
    logic                      is_store_q [lsq_depth];
    logic                      size_q     [lsq_depth];
    logic [mem_addr_width-1:0] address_q  [lsq_depth];
    logic [data_width-1:0]     data_q     [lsq_depth];
    logic [rob_tag_width-1:0]  rob_tag_q  [lsq_depth];

    logic [lsq_ptr_width-1:0] head_ptr;
    logic [lsq_ptr_width-1:0] tail_ptr;
    logic [lsq_ptr_width:0]   count;   // One extra bit to tell full from empty
    logic                     push;
    logic                     pop;

    assign enq_ready  = (count != lsq_depth);
    assign head_valid = (count != 0);
    assign push       = enq_valid & enq_ready;
    assign pop        = deq;

    always_ff @(posedge clk) begin
        if (reset) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (push) tail_ptr <= tail_ptr + 1'b1;  // Wraps at lsq_depth
            if (pop)  head_ptr <= head_ptr + 1'b1;
            if (push && !pop) count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            is_store_q[tail_ptr] <= enq_is_store;
            size_q[tail_ptr]     <= enq_size;
            address_q[tail_ptr]  <= enq_address;
            data_q[tail_ptr]     <= enq_data;
            rob_tag_q[tail_ptr]  <= enq_rob_tag;
        end
    end

    assign head_is_store = is_store_q[head_ptr];
    assign head_size     = size_q[head_ptr];
    assign head_address  = address_q[head_ptr];
    assign head_data     = data_q[head_ptr];
    assign head_rob_tag  = rob_tag_q[head_ptr];

    // Controller only dequeues a present entry
    a_no_deq_empty: assert property (@(posedge clk) disable iff (reset)
        deq |-> head_valid);

    // Tail leads head by the entry count and the count stops at the depth
    a_no_write_full: assert property (@(posedge clk) disable iff (reset)
        (count <= lsq_depth) && (tail_ptr == head_ptr + count[lsq_ptr_width-1:0]));

endmodule

// ==== source/memory_controller.sv ====
// Issues the queue head to data memory, loads when the result slot is free
// Stores wait for the ROB commit, one issue per cycle

`timescale 1ns/1ns

module memory_controller
    import mem_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      head_valid,
    input  logic                      head_is_store,
    input  logic                      head_size,
    input  logic [mem_addr_width-1:0] head_address,
    input  logic [data_width-1:0]     head_data,
    input  logic [rob_tag_width-1:0]  head_rob_tag,
    input  logic                      rob_head_store,
    input  logic                      cdb_yummy,
    output logic                      deq,
    output logic                      store_retire,
    output logic                      mem_read,
    output logic                      mem_write,
    output logic                      mem_size,
    output logic [mem_addr_width-1:0] mem_address,
    output logic [data_width-1:0]     mem_wdata,
    input  logic [data_width-1:0]     mem_rdata,
    output logic                      cdb_valid,
    output logic [rob_tag_width-1:0]  cdb_rob_tag,
    output logic [data_width-1:0]     cdb_result
);

    logic load_issue;
    logic store_issue;
    logic slot_free;

    assign slot_free   = ~cdb_valid | cdb_yummy;  // Empty or taken this cycle
    assign load_issue  = head_valid & ~head_is_store & slot_free;
    assign store_issue = head_valid & head_is_store & rob_head_store;

    assign deq          = load_issue | store_issue;
    assign store_retire = store_issue;

    assign mem_read    = load_issue;
    assign mem_write   = store_issue;
    assign mem_size    = head_size;
    assign mem_address = head_address;
    assign mem_wdata   = head_data;

    // Result slot, refill wins over yummy
    always_ff @(posedge clk) begin
        if (reset) cdb_valid <= 1'b0;
        else if (load_issue) cdb_valid <= 1'b1;
        else if (cdb_yummy) cdb_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (load_issue) begin
            cdb_result  <= mem_rdata;
            cdb_rob_tag <= head_rob_tag;
        end
    end

    a_read_write_excl: assert property (@(posedge clk) disable iff (reset)
        !(mem_read && mem_write));

    // Bus sees a held result until it grants it
    a_result_held: assert property (@(posedge clk) disable iff (reset)
        cdb_valid && !cdb_yummy |=> cdb_valid && $stable(cdb_result)
            && $stable(cdb_rob_tag));

endmodule

// ==== source/data_memory.sv ====
// Word-organized RAM, combinational read and synchronous byte-lane write
// Word accesses drop the two low address bits, byte reads are zero-extended

`timescale 1ns/1ns

module data_memory
    import mem_pkg::*;
(
    input  logic                      clk,
    input  logic                      read,
    input  logic                      write,
    input  logic                      size,
    input  logic [mem_addr_width-1:0] address,
    input  logic [data_width-1:0]     wdata,
    output logic [data_width-1:0]     rdata
);

    mem_word_u mem [mem_words];

    logic [mem_addr_width-3:0] index;
    logic [1:0]                lane;

    assign index = address[mem_addr_width-1:2];
    assign lane  = address[1:0];

    initial begin
        for (int i = 0; i < mem_words; i++) mem[i] = '0;
    end

    always_comb begin
        rdata = '0;
        if (read) begin
            case (size)
                size_word: rdata = mem[index].word;
                size_byte: rdata = {{(data_width-8){1'b0}}, mem[index].lanes[lane]};
                default:   rdata = '0;
            endcase
        end
    end

    // Byte store touches only its lane
    always_ff @(posedge clk) begin
        if (write) begin
            if (size == size_word) mem[index].word <= wdata;
            else mem[index].lanes[lane] <= wdata[7:0];
        end
    end

    a_address_range: assert property (@(posedge clk)
        (read || write) |-> !$isunknown(address) && (int'(index) < mem_words));

endmodule

// ==== source/memory_stage.sv ====
// Memory stage top: queue, controller and data memory
// Strictly in order, a load waits behind any uncommitted older store

`timescale 1ns/1ns

module memory_stage
    import mem_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      enq_valid,
    input  logic                      enq_is_store,
    input  logic                      enq_size,
    input  logic [mem_addr_width-1:0] enq_address,
    input  logic [data_width-1:0]     enq_data,
    input  logic [rob_tag_width-1:0]  enq_rob_tag,
    output logic                      enq_ready,
    input  logic                      rob_head_store,
    output logic                      store_retire,
    input  logic                      cdb_yummy,
    output logic                      cdb_valid,
    output logic [rob_tag_width-1:0]  cdb_rob_tag,
    output logic [data_width-1:0]     cdb_result
);

    // Queue head
    logic                      head_valid;
    logic                      head_is_store;
    logic                      head_size;
    logic [mem_addr_width-1:0] head_address;
    logic [data_width-1:0]     head_data;
    logic [rob_tag_width-1:0]  head_rob_tag;
    logic                      deq;

    // Memory port
    logic                      mem_read;
    logic                      mem_write;
    logic                      mem_size;
    logic [mem_addr_width-1:0] mem_address;
    logic [data_width-1:0]     mem_wdata;
    logic [data_width-1:0]     mem_rdata;

    load_store_queue u_queue (
        .clk           (clk),
        .reset         (reset),
        .enq_valid     (enq_valid),
        .enq_is_store  (enq_is_store),
        .enq_size      (enq_size),
        .enq_address   (enq_address),
        .enq_data      (enq_data),
        .enq_rob_tag   (enq_rob_tag),
        .enq_ready     (enq_ready),
        .deq           (deq),
        .head_valid    (head_valid),
        .head_is_store (head_is_store),
        .head_size     (head_size),
        .head_address  (head_address),
        .head_data     (head_data),
        .head_rob_tag  (head_rob_tag)
    );

    memory_controller u_controller (
        .clk            (clk),
        .reset          (reset),
        .head_valid     (head_valid),
        .head_is_store  (head_is_store),
        .head_size      (head_size),
        .head_address   (head_address),
        .head_data      (head_data),
        .head_rob_tag   (head_rob_tag),
        .rob_head_store (rob_head_store),
        .cdb_yummy      (cdb_yummy),
        .deq            (deq),
        .store_retire   (store_retire),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .mem_size       (mem_size),
        .mem_address    (mem_address),
        .mem_wdata      (mem_wdata),
        .mem_rdata      (mem_rdata),
        .cdb_valid      (cdb_valid),
        .cdb_rob_tag    (cdb_rob_tag),
        .cdb_result     (cdb_result)
    );

    data_memory u_data_memory (
        .clk     (clk),
        .read    (mem_read),
        .write   (mem_write),
        .size    (mem_size),
        .address (mem_address),
        .wdata   (mem_wdata),
        .rdata   (mem_rdata)
    );

endmodule

// ==== verif/mem_ref_model.svh ====
// Reference model for the memory stage testbench, included inside the testbench module
// Relies on mem_pkg being imported by the including module

`ifndef MEM_REF_MODEL_SVH
`define MEM_REF_MODEL_SVH

// Galois LFSR, polynomial x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return (state >> 1) ^ (state[0] ? 32'h8020_0003 : 32'h0);
endfunction

mem_word_u ref_mem [mem_words];  // Committed memory state in program order

task automatic clear_ref_memory();
    for (int i = 0; i < mem_words; i++) ref_mem[i].word = '0;
endtask

function automatic int unsigned word_index(input logic [mem_addr_width-1:0] address);
    return address >> 2;
endfunction

// Load value at this point in program order
function automatic logic [data_width-1:0] expected_load(input logic size,
                                                      input logic [mem_addr_width-1:0] address);
    logic [data_width-1:0] word;
    int unsigned           shift;
    word  = ref_mem[word_index(address)].word;
    shift = 8 * address[1:0];
    if (size == size_word) return word;
    return (word >> shift) & 32'h0000_00ff;  // Byte load, zero-extended
endfunction

task automatic apply_store(input logic size, input logic [mem_addr_width-1:0] address,
                           input logic [data_width-1:0] data);
    logic [data_width-1:0] mask;
    int unsigned           idx;
    int unsigned           shift;
    idx   = word_index(address);
    shift = 8 * address[1:0];
    if (size == size_word) begin
        ref_mem[idx].word = data;
    end else begin
        mask = 32'h0000_00ff << shift;
        ref_mem[idx].word = (ref_mem[idx].word & ~mask) | ((data & 32'h0000_00ff) << shift);
    end
endtask

`endif

// ==== verif/memory_stage_tb.sv ====
// Random loads and stores through the memory stage with ROB commit and bus back-pressure
// The ROB is modeled only as far as its head-is-store signal

`timescale 1ns/1ns

module memory_stage_tb
    import mem_pkg::*;
();

    localparam logic [31:0] lfsr_seed    = 32'h5c29_28b2;
    localparam int          op_count     = 200;
    localparam int          cycle_limit  = op_count * 20;
    localparam int          clock_period = 40;
    localparam int          random_ops   = 170;

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      enq_valid;
    logic                      enq_is_store;
    logic                      enq_size;
    logic [mem_addr_width-1:0] enq_address;
    logic [data_width-1:0]     enq_data;
    logic [rob_tag_width-1:0]  enq_rob_tag;
    logic                      enq_ready;
    logic                      rob_head_store;
    logic                      store_retire;
    logic                      cdb_yummy;
    logic                      cdb_valid;
    logic [rob_tag_width-1:0]  cdb_rob_tag;
    logic [data_width-1:0]     cdb_result;

    `include "mem_ref_model.svh"

    logic [31:0] lfsr_state = lfsr_seed;

    // Unresolved dispatched operations in program order
    logic                      prog_is_store [$];
    logic                      prog_size     [$];
    logic [mem_addr_width-1:0] prog_addr     [$];
    logic [data_width-1:0]     prog_data     [$];
    logic [rob_tag_width-1:0]  prog_tag      [$];

    // Loads resolved by the model and waiting for the bus
    logic [rob_tag_width-1:0]  exp_tag       [$];
    logic [data_width-1:0]     exp_result    [$];

    int                        commit_hold_cycles = 0;
    int                        yummy_hold_cycles  = 0;
    logic [rob_tag_width-1:0]  next_tag           = '0;
    int                        cycle_count        = 0;
    int                        error_count        = 0;
    int                        stores_sent        = 0;
    int                        stores_retired     = 0;
    int                        loads_sent         = 0;
    int                        loads_checked      = 0;
    logic                      held_valid         = 1'b0;
    logic [data_width-1:0]     held_result;
    logic [rob_tag_width-1:0]  held_tag;

    memory_stage u_memory_stage (
        .clk            (clk),
        .reset          (reset),
        .enq_valid      (enq_valid),
        .enq_is_store   (enq_is_store),
        .enq_size       (enq_size),
        .enq_address    (enq_address),
        .enq_data       (enq_data),
        .enq_rob_tag    (enq_rob_tag),
        .enq_ready      (enq_ready),
        .rob_head_store (rob_head_store),
        .store_retire   (store_retire),
        .cdb_yummy      (cdb_yummy),
        .cdb_valid      (cdb_valid),
        .cdb_rob_tag    (cdb_rob_tag),
        .cdb_result     (cdb_result)
    );

    always #(clock_period / 2) clk = ~clk;

    task automatic fail_run();
        error_count++;
        $display("Test failed");
        $fatal(1, "Stopped at the first error");
    endtask

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits[i]    = lfsr_state[0];
        end
        return bits;
    endfunction

    // ROB and bus side inputs on the falling edge
    task automatic advance_cycle();
        @(negedge clk);
        if (commit_hold_cycles > 0) begin
            commit_hold_cycles--;
            rob_head_store = 1'b0;
        end else begin
            // Store is the ROB head once every older load has left the bus
            rob_head_store = prog_is_store.size() > 0 && prog_is_store[0]
                && exp_tag.size() == 0 && take_bits(2) != 0;
        end
        if (yummy_hold_cycles > 0) begin
            yummy_hold_cycles--;
            cdb_yummy = 1'b0;
        end else begin
            cdb_yummy = take_bits(2) != 0;
        end
    endtask

    task automatic idle_cycles(input int cycles);
        repeat (cycles) begin
            advance_cycle();
            enq_valid = 1'b0;
        end
    endtask

    task automatic enqueue_op(input logic is_store, input logic size,
                              input logic [mem_addr_width-1:0] address,
                              input logic [data_width-1:0] data);
        advance_cycle();
        enq_valid    = 1'b1;
        enq_is_store = is_store;
        enq_size     = size;
        enq_address  = address;
        enq_data     = data;
        enq_rob_tag  = next_tag;
        @(posedge clk);
        while (!enq_ready) begin  // Held until the queue has room
            advance_cycle();
            @(posedge clk);
        end
        next_tag++;
        if (is_store) stores_sent++;
        else loads_sent++;
    endtask

    task automatic random_op(input logic loads_only);
        logic                      is_store;
        logic                      size;
        logic [mem_addr_width-1:0] address;
        logic [data_width-1:0]     data;
        if (take_bits(2) == 0) idle_cycles(1);  // Dispatch gap
        is_store = loads_only ? 1'b0 : (take_bits(1) != 0);
        size     = take_bits(1) != 0;
        address  = 10'h0a0 | 10'(take_bits(5));  // Eight words for frequent reuse
        data     = take_bits(32);
        enqueue_op(is_store, size, address, data);
    endtask

    task automatic wait_drained();
        idle_cycles(1);
        while (prog_is_store.size() > 0 || exp_tag.size() > 0) idle_cycles(1);
    endtask

    task automatic drop_prog_front();
        void'(prog_is_store.pop_front());
        void'(prog_size.pop_front());
        void'(prog_addr.pop_front());
        void'(prog_data.pop_front());
        void'(prog_tag.pop_front());
    endtask

    // Program-order model on the values sampled at each rising edge
    always @(posedge clk) begin
        if (!reset) begin
            if (store_retire) begin
                assert (prog_is_store.size() > 0 && prog_is_store[0] && rob_head_store)
                else begin
                    $display("A store retired that was not the committed oldest operation");
                    fail_run();
                end
                apply_store(prog_size[0], prog_addr[0], prog_data[0]);
                drop_prog_front();
                stores_retired++;
            end
            if (enq_valid && enq_ready) begin
                prog_is_store.push_back(enq_is_store);
                prog_size.push_back(enq_size);
                prog_addr.push_back(enq_address);
                prog_data.push_back(enq_data);
                prog_tag.push_back(enq_rob_tag);
            end
            // Loads with no older store pending get their value now
            while (prog_is_store.size() > 0 && !prog_is_store[0]) begin
                exp_tag.push_back(prog_tag[0]);
                exp_result.push_back(expected_load(prog_size[0], prog_addr[0]));
                drop_prog_front();
            end
        end
    end

    // Data bus checks
    always @(posedge clk) begin
        if (!reset) begin
            if (held_valid) begin
                assert (cdb_valid && cdb_result == held_result && cdb_rob_tag == held_tag)
                else begin
                    $display("** Error: held cdb_valid %h cdb_result %h->%h cdb_rob_tag %h->%h",
                             cdb_valid, held_result, cdb_result, held_tag, cdb_rob_tag);
                    fail_run();
                end
            end
            if (cdb_valid) begin
                assert (exp_tag.size() > 0) else begin
                    $display("A result is on the data bus while no load is due in program order");
                    fail_run();
                end
                if (cdb_yummy) begin
                    assert (cdb_rob_tag == exp_tag[0]) else begin
                        $display("** Error: cdb_rob_tag expected %h, got %h",
                                 exp_tag[0], cdb_rob_tag);
                        fail_run();
                    end
                    assert (cdb_result == exp_result[0]) else begin
                        $display("** Error: cdb_result expected %h, got %h",
                                 exp_result[0], cdb_result);
                        fail_run();
                    end
                    void'(exp_tag.pop_front());
                    void'(exp_result.pop_front());
                    loads_checked++;
                end
            end
            held_valid  = cdb_valid && !cdb_yummy;
            held_result = cdb_result;
            held_tag    = cdb_rob_tag;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
            fail_run();
        end
    end

    initial begin
        reset          = 1'b1;
        enq_valid      = 1'b0;
        enq_is_store   = 1'b0;
        enq_size       = size_word;
        enq_address    = '0;
        enq_data       = '0;
        enq_rob_tag    = '0;
        rob_head_store = 1'b0;
        cdb_yummy      = 1'b0;
        clear_ref_memory();  // Data memory starts at zero too
        repeat (4) @(negedge clk);
        reset = 1'b0;

        repeat (5) begin
            idle_cycles(1);
            assert (!cdb_valid && !store_retire && enq_ready) else begin
                $display(
                    "** Error: cdb_valid %h store_retire %h enq_ready %h, expected 0 0 1",
                    cdb_valid, store_retire, enq_ready);
                fail_run();
            end
        end

        // Word store then word load of the same word
        enqueue_op(1'b1, size_word, 10'h040, 32'hcafe_f00d);
        enqueue_op(1'b0, size_word, 10'h040, 32'h0);
        // Byte store into lane 1 then word and byte loads
        enqueue_op(1'b1, size_word, 10'h080, 32'h1122_3344);
        enqueue_op(1'b1, size_byte, 10'h081, 32'hffff_ffab);
        enqueue_op(1'b0, size_word, 10'h082, 32'h0);  // Low address bits ignored
        enqueue_op(1'b0, size_byte, 10'h081, 32'h0);
        enqueue_op(1'b0, size_byte, 10'h083, 32'h0);
        wait_drained();
        assert (expected_load(size_word, 10'h080) == 32'h1122_ab44) else begin
            $display("** Error: ref_mem word 080 expected 1122ab44, got %h",
                     expected_load(size_word, 10'h080));
            fail_run();
        end

        // Loads back up behind a result the bus holds
        yummy_hold_cycles = 25;
        repeat (4) random_op(1'b1);
        wait_drained();

        // Uncommitted store at the head until the queue fills
        commit_hold_cycles = 40;
        enqueue_op(1'b1, size_word, 10'h0a4, take_bits(32));
        repeat (lsq_depth - 1) random_op(1'b1);
        idle_cycles(1);
        assert (!enq_ready) else begin
            $display("** Error: enq_ready expected 0 with a full queue, got %h", enq_ready);
            fail_run();
        end
        random_op(1'b0);  // Accepted once the store commits
        wait_drained();

        repeat (random_ops) random_op(1'b0);
        wait_drained();

        assert (stores_retired == stores_sent && loads_checked == loads_sent) else begin
            $display("Operations lost: %0d of %0d stores retired, %0d of %0d loads returned",
                     stores_retired, stores_sent, loads_checked, loads_sent);
            fail_run();
        end
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+verif
source/mem_pkg.sv
source/load_store_queue.sv
source/memory_controller.sv
source/data_memory.sv
source/memory_stage.sv
verif/memory_stage_tb.sv

// ==== Bender.yml ====
package:
  name: memory_stage

sources:
  # Memory stage RTL
  - files:
      - source/mem_pkg.sv
      - source/load_store_queue.sv
      - source/memory_controller.sv
      - source/data_memory.sv
      - source/memory_stage.sv
  # Testbench
  - target: test
    include_dirs:
      - verif
    files:
      - verif/memory_stage_tb.sv
